// ==== logic/scope_pkg.sv ====
`default_nettype none

package scope_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample and trigger types
    ////////////////////////////////////////////////////////////////////////////

    // ADC sample width
    localparam int SAMPLE_W = 8;

    // Trigger modes, encoded as CTRL[2:1]
    typedef enum logic [1:0] {
        trig_rising,
        trig_falling,
        trig_level,
        trig_immediate
    } trig_mode_e;

    // Capture sequencer states, reported in STATUS[1:0]
    typedef enum logic [1:0] {
        seq_idle,
        seq_wait,
        seq_fill,
        seq_done
    } seq_state_e;

    // One registered sample plus its trigger flag
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
        logic                hit;
    } sample_beat_t;

    // Software configuration
    typedef struct packed {
        trig_mode_e          mode;
        logic [SAMPLE_W-1:0] level;
        logic [SAMPLE_W-1:0] hyst;
        logic [8:0]          count;
    } capture_cfg_t;

    // Sequencer state seen by software
    typedef struct packed {
        seq_state_e state;
        logic [8:0] fill;
    } capture_status_t;

    // Buffer write request
    typedef struct packed {
        logic                wr_en;
        logic [7:0]          addr;
        logic [SAMPLE_W-1:0] data;
    } buf_wr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register map, byte addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [31:0] REG_CTRL   = 32'h0000_0000;
    localparam logic [31:0] REG_LEVEL  = 32'h0000_0004;
    localparam logic [31:0] REG_HYST   = 32'h0000_0008;
    localparam logic [31:0] REG_COUNT  = 32'h0000_000C;
    localparam logic [31:0] REG_STATUS = 32'h0000_0010;
    // Buffer word i at BUF_BASE + 4*i
    localparam logic [31:0] BUF_BASE   = 32'h0000_0400;

endpackage

`default_nettype wire

// ==== logic/trigger_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module trigger_detect (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [scope_pkg::SAMPLE_W-1:0] sample,
    input  logic                           sample_valid,
    input  scope_pkg::capture_cfg_t        cfg,
    output scope_pkg::sample_beat_t        beat,
    output logic                           beat_valid
);

    import scope_pkg::*;

    // Hysteresis thresholds
    logic [SAMPLE_W:0]   sum_c;
    logic [SAMPLE_W-1:0] hi_thr;
    logic [SAMPLE_W-1:0] lo_thr;

    // Edge qualifier
    logic       armed_q;
    logic       armed_nxt;
    logic       armed_eff;
    trig_mode_e mode_q;
    logic       hit_c;

    // Output registers
    logic [SAMPLE_W-1:0] beat_data_q;
    logic                beat_hit_q;

    ////////////////////////////////////////////////////////////////////////////
    // Thresholds, saturating at both ends of the sample range
    ////////////////////////////////////////////////////////////////////////////

    assign sum_c  = {1'b0, cfg.level} + {1'b0, cfg.hyst};
    assign hi_thr = sum_c[SAMPLE_W] ? '1 : sum_c[SAMPLE_W-1:0];
    assign lo_thr = (cfg.level > cfg.hyst) ? cfg.level - cfg.hyst : '0;

    // Flag armed under another mode does not count
    assign armed_eff = armed_q && (mode_q == cfg.mode);

    ////////////////////////////////////////////////////////////////////////////
    // Trigger rule per mode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_c     = 1'b0;
        armed_nxt = armed_eff;
        unique case (cfg.mode)
            trig_rising: begin
                // Need a dip to level-hyst before the next crossing
                if (armed_eff && sample >= cfg.level) begin
                    hit_c     = 1'b1;
                    armed_nxt = 1'b0;
                end else if (sample <= lo_thr) begin
                    armed_nxt = 1'b1;
                end
            end
            trig_falling: begin
                // Mirror of rising, arms above level+hyst
                if (armed_eff && sample <= cfg.level) begin
                    hit_c     = 1'b1;
                    armed_nxt = 1'b0;
                end else if (sample >= hi_thr) begin
                    armed_nxt = 1'b1;
                end
            end
            trig_level: begin
                hit_c     = (sample >= cfg.level);
                armed_nxt = 1'b0;
            end
            trig_immediate: begin
                hit_c     = 1'b1;
                armed_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat_valid <= 1'b0;
            beat_hit_q <= 1'b0;
            armed_q    <= 1'b0;
            mode_q     <= trig_rising;
        end else begin
            beat_valid <= sample_valid;
            beat_hit_q <= sample_valid && hit_c;
            // Qualifier only moves on real samples
            if (sample_valid) begin
                armed_q <= armed_nxt;
                mode_q  <= cfg.mode;
            end
        end
    end

    // Sample payload
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            beat_data_q <= sample;
        end
    end

    assign beat = '{data: beat_data_q, hit: beat_hit_q};

    // A hit always comes from a sample strobed one cycle earlier
    a_hit_valid: assert property (@(posedge clk) disable iff (!rst)
        beat.hit |-> beat_valid && $past(sample_valid));

endmodule

`default_nettype wire

// ==== logic/capture_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module capture_sequencer #(
    parameter int DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       arm,
    input  scope_pkg::capture_cfg_t    cfg,
    input  scope_pkg::sample_beat_t    beat,
    input  logic                       beat_valid,
    output scope_pkg::buf_wr_t         wr,
    output scope_pkg::capture_status_t status
);

    import scope_pkg::*;

    localparam logic [8:0] DEPTH_W = 9'(DEPTH);

    seq_state_e state_q;
    seq_state_e state_d;
    logic [8:0] fill_q;
    logic [8:0] fill_d;
    logic [8:0] target_c;
    logic       wr_en_c;

    // Zero or oversize count means a full buffer
    assign target_c = (cfg.count == '0 || cfg.count > DEPTH_W) ? DEPTH_W : cfg.count;

    ////////////////////////////////////////////////////////////////////////////
    // Write request, same cycle as the beat
    ////////////////////////////////////////////////////////////////////////////

    // Arm wins over a beat in the same cycle
    assign wr_en_c = beat_valid && !arm &&
                     ((state_q == seq_wait && beat.hit) || state_q == seq_fill);

    always_comb begin
        state_d = state_q;
        fill_d  = fill_q;
        if (arm) begin
            // Restart from any state
            state_d = seq_wait;
            fill_d  = '0;
        end else if (wr_en_c) begin
            fill_d  = fill_q + 9'd1;
            state_d = (fill_d >= target_c) ? seq_done : seq_fill;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= seq_idle;
            fill_q  <= '0;
        end else begin
            state_q <= state_d;
            fill_q  <= fill_d;
        end
    end

    // Fill count doubles as write address
    assign wr     = '{wr_en: wr_en_c, addr: fill_q[7:0], data: beat.data};
    assign status = '{state: state_q, fill: fill_q};

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_wr_state: assert property (@(posedge clk) disable iff (!rst)
        wr.wr_en |-> (state_q inside {seq_wait, seq_fill}));

    a_fill_max: assert property (@(posedge clk) disable iff (!rst)
        fill_q <= DEPTH_W);

endmodule

`default_nettype wire

// ==== logic/capture_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module capture_buffer #(
    parameter int DEPTH = 256
) (
    input  logic                           clk,
    input  scope_pkg::buf_wr_t             wr,
    input  logic [7:0]                     rd_addr,
    output logic [scope_pkg::SAMPLE_W-1:0] rd_data
);

    import scope_pkg::*;

    // Sample storage, simple dual port
    logic [SAMPLE_W-1:0] mem [DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Write port, driven by the sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port, one cycle latency
    ////////////////////////////////////////////////////////////////////////////

    // Registered output for block RAM inference
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Sequencer must clip its count to the buffer size
    a_wr_range: assert property (@(posedge clk)
        wr.wr_en |-> wr.addr < DEPTH);

endmodule

`default_nettype wire

// ==== logic/axil_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_regs #(
    parameter int DEPTH   = 256,
    parameter int AXIL_AW = 12
) (
    input  logic                           clk,
    input  logic                           rst,
    // Write address and data
    input  logic [AXIL_AW-1:0]             awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic                           wvalid,
    output logic                           wready,
    // Write response
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    // Read address and data
    input  logic [AXIL_AW-1:0]             araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    // Core side
    output scope_pkg::capture_cfg_t        cfg,
    output logic                           arm,
    input  scope_pkg::capture_status_t     status,
    output logic [7:0]                     rd_addr,
    input  logic [scope_pkg::SAMPLE_W-1:0] rd_data
);

    import scope_pkg::*;

    // Low until the first cycle out of reset
    logic ready_q;

    logic [31:0] aw_addr32;
    logic [31:0] ar_addr32;
    logic [31:0] ar_off;
    logic        wr_fire;
    logic        rd_fire;
    logic        ar_in_buf;

    // Config registers
    trig_mode_e          mode_q;
    logic [SAMPLE_W-1:0] level_q;
    logic [SAMPLE_W-1:0] hyst_q;
    logic [8:0]          count_q;

    // Read path
    logic        rfirst_q;
    logic        buf_sel_q;
    logic [31:0] reg_val_c;
    logic [31:0] buf_word_c;
    logic [31:0] rhold_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    assign aw_addr32 = 32'(awaddr);
    assign ar_addr32 = 32'(araddr);

    ////////////////////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////////////////////

    // AW and W taken together, never with a response outstanding
    assign awready = ready_q && !bvalid && awvalid && wvalid;
    assign wready  = awready;
    assign wr_fire = awvalid && awready;
    assign bresp   = 2'b00;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode_q  <= trig_rising;
            level_q <= '0;
            hyst_q  <= '0;
            count_q <= '0;
            arm     <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // Arm is a one-cycle pulse
            arm <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                case (aw_addr32)
                    REG_CTRL: begin
                        arm    <= wdata[0];
                        mode_q <= trig_mode_e'(wdata[2:1]);
                    end
                    REG_LEVEL: level_q <= wdata[SAMPLE_W-1:0];
                    REG_HYST:  hyst_q  <= wdata[SAMPLE_W-1:0];
                    REG_COUNT: count_q <= wdata[8:0];
                    // Status and buffer are read only
                    default: ;
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    assign cfg = '{mode: mode_q, level: level_q, hyst: hyst_q, count: count_q};

    ////////////////////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////////////////////

    assign arready = ready_q && !rvalid;
    assign rd_fire = arvalid && arready;
    assign rresp   = 2'b00;

    // Buffer window decode, word index straight to the RAM
    assign ar_off    = ar_addr32 - BUF_BASE;
    assign ar_in_buf = (ar_addr32 >= BUF_BASE) && (ar_addr32 < BUF_BASE + 32'(4 * DEPTH));
    assign rd_addr   = ar_off[9:2];

    always_comb begin
        case (ar_addr32)
            REG_CTRL:   reg_val_c = {29'b0, mode_q, 1'b0};
            REG_LEVEL:  reg_val_c = 32'(level_q);
            REG_HYST:   reg_val_c = 32'(hyst_q);
            REG_COUNT:  reg_val_c = 32'(count_q);
            REG_STATUS: reg_val_c = {15'b0, status.fill, 6'b0, status.state};
            // Unmapped and buffer space
            default:    reg_val_c = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rvalid    <= 1'b0;
            rfirst_q  <= 1'b0;
            buf_sel_q <= 1'b0;
        end else begin
            rfirst_q <= rd_fire;
            if (rd_fire) begin
                rvalid    <= 1'b1;
                buf_sel_q <= ar_in_buf;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    assign buf_word_c = 32'(rd_data);

    // Register values latched at AR, buffer word latched on its first cycle
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rhold_q <= reg_val_c;
        end else if (rfirst_q && buf_sel_q) begin
            rhold_q <= buf_word_c;
        end
    end

    // RAM output used directly while it is fresh
    assign rdata = (rfirst_q && buf_sel_q) ? buf_word_c : rhold_q;

    ////////////////////////////////////////////////////////////////////////////
    // Response hold
    ////////////////////////////////////////////////////////////////////////////

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid && !bready |=> bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// ==== logic/scope_capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module scope_capture_top #(
    parameter int DEPTH   = 256,
    parameter int AXIL_AW = 12
) (
    input  logic                           clk,
    input  logic                           rst,
    // AXI4-Lite slave
    input  logic [AXIL_AW-1:0]             awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [AXIL_AW-1:0]             araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    // ADC stream, no stall
    input  logic [scope_pkg::SAMPLE_W-1:0] sample,
    input  logic                           sample_valid
);

    import scope_pkg::*;

    capture_cfg_t        cfg;
    logic                arm;
    sample_beat_t        beat;
    logic                beat_valid;
    buf_wr_t             wr;
    capture_status_t     status;
    logic [7:0]          rd_addr;
    logic [SAMPLE_W-1:0] rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Sample path
    ////////////////////////////////////////////////////////////////////////////

    trigger_detect trig0 (
        .clk          (clk),
        .rst          (rst),
        .sample       (sample),
        .sample_valid (sample_valid),
        .cfg          (cfg),
        .beat         (beat),
        .beat_valid   (beat_valid)
    );

    capture_sequencer #(.DEPTH(DEPTH)) seq0 (
        .clk        (clk),
        .rst        (rst),
        .arm        (arm),
        .cfg        (cfg),
        .beat       (beat),
        .beat_valid (beat_valid),
        .wr         (wr),
        .status     (status)
    );

    capture_buffer #(.DEPTH(DEPTH)) buf0 (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Register block
    ////////////////////////////////////////////////////////////////////////////

    axil_regs #(.DEPTH(DEPTH), .AXIL_AW(AXIL_AW)) regs0 (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cfg     (cfg),
        .arm     (arm),
        .status  (status),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== tests/scope_capture_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module scope_capture_tb;

    localparam int DEPTH   = 256;
    localparam int AXIL_AW = 12;
    localparam int PAT_MAX = 512;

    // Register map
    localparam logic [11:0] REG_CTRL   = 12'h000;
    localparam logic [11:0] REG_LEVEL  = 12'h004;
    localparam logic [11:0] REG_HYST   = 12'h008;
    localparam logic [11:0] REG_COUNT  = 12'h00C;
    localparam logic [11:0] REG_STATUS = 12'h010;
    localparam logic [11:0] BUF_BASE   = 12'h400;

    // STATUS[1:0] codes
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd3;

    // Pattern file markers
    localparam logic [15:0] GEN_FLAG = 16'h8000;
    localparam logic [15:0] END_MARK = 16'hFFFF;

    logic               clk;
    logic               rst;
    logic [AXIL_AW-1:0] awaddr;
    logic               awvalid;
    logic               awready;
    logic [31:0]        wdata;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    logic [AXIL_AW-1:0] araddr;
    logic               arvalid;
    logic               arready;
    logic [31:0]        rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;
    logic [7:0]         sample;
    logic               sample_valid;

    logic [15:0] pat [PAT_MAX];
    int          cycles = 0;
    int          cycle_limit = 1000;

    scope_capture_top #(.DEPTH(DEPTH), .AXIL_AW(AXIL_AW)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // 100 ns clock
    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        abort_run();
    endtask

    task automatic fail_text(input string why);
        $display("%s", why);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Every byte value once over 256 entries
    function automatic logic [7:0] ramp_value(input int i);
        return 8'((i * 7 + 3) & 255);
    endfunction

    // Zero or oversize count means a full buffer
    function automatic int expected_fill(input logic [8:0] count);
        if (count == 0 || count > DEPTH) begin
            return DEPTH;
        end
        return int'(count);
    endfunction

    function automatic int field_len(input logic [15:0] word);
        return int'(word & 16'h7FFF);
    endfunction

    // Samples plus AXI transfers in the whole pattern file
    function automatic int planned_steps();
        int p;
        int n;
        int steps;
        p = 0;
        steps = 1;
        while (p < PAT_MAX - 8 && pat[p] !== END_MARK) begin
            // Config, readback, arm, status and a couple of polls
            steps = steps + 12;
            p = p + 4;
            n = field_len(pat[p]);
            steps = steps + n;
            p = p + 1 + (((pat[p] & GEN_FLAG) != 0) ? 0 : n);
            n = field_len(pat[p]);
            steps = steps + n;
            p = p + 1 + (((pat[p] & GEN_FLAG) != 0) ? 0 : n);
        end
        return steps;
    endfunction

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        int hold;
        hold = $urandom_range(2, 0);
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        // Acceptance shows up as BVALID one edge later
        do @(negedge clk); while (!bvalid);
        // Valids still high, so a second acceptance would show here
        assert (!awready && !wready)
            else fail_text("write channel ready while a write response was pending");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_value("bresp", 32'(bresp), 32'h0);
        repeat (hold) begin
            @(negedge clk);
            assert (bvalid) else fail_text("write response dropped while BREADY was low");
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        assert (!bvalid) else fail_text("write response repeated after its handshake");
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        int hold;
        hold = $urandom_range(2, 0);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!rvalid);
        // No new read address while the response is outstanding
        assert (!arready)
            else fail_text("read address ready while a read response was pending");
        arvalid = 1'b0;
        data = rdata;
        check_value("rresp", 32'(rresp), 32'h0);
        // Data must not move while RREADY is low
        repeat (hold) begin
            @(negedge clk);
            assert (rvalid) else fail_text("read response dropped while RREADY was low");
            check_value("rdata", rdata, data);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        assert (!rvalid) else fail_text("read response repeated after its handshake");
        assert (arready)
            else fail_text("read address not ready after the read response completed");
    endtask

    // One sample, then a random idle gap
    task automatic send_sample(input logic [7:0] value);
        int gap;
        gap = $urandom_range(2, 0);
        @(negedge clk);
        sample       = value;
        sample_valid = 1'b1;
        repeat (gap) begin
            @(negedge clk);
            sample_valid = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          p;
        int          idx;
        logic        gen;
        logic [15:0] nsamp;
        logic [15:0] nexp;
        logic [1:0]  mode;
        logic [7:0]  level;
        logic [7:0]  hyst;
        logic [8:0]  count;
        logic [7:0]  exp_word;
        logic [31:0] rd;

        rst          = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        void'($urandom(32'h2d47_0486));

        $readmemh("tests/scope_capture_patterns.txt", pat);
        assert (!$isunknown(pat[0]))
            else fail_text("pattern file tests/scope_capture_patterns.txt is missing or empty");
        cycle_limit = 4 * planned_steps() + 1000;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Idle with nothing stored
        axi_read(REG_STATUS, rd);
        check_value("status", rd, 32'h0);

        p = 0;
        while (pat[p] !== END_MARK) begin
            mode  = pat[p][1:0];
            level = pat[p + 1][7:0];
            hyst  = pat[p + 2][7:0];
            count = pat[p + 3][8:0];
            p = p + 4;

            // Config and readback, arm bit clear
            axi_write(REG_LEVEL, 32'(level));
            axi_write(REG_HYST, 32'(hyst));
            axi_write(REG_COUNT, 32'(count));
            axi_write(REG_CTRL, {29'b0, mode, 1'b0});
            axi_read(REG_LEVEL, rd);
            check_value("level", rd, 32'(level));
            axi_read(REG_HYST, rd);
            check_value("hyst", rd, 32'(hyst));
            axi_read(REG_COUNT, rd);
            check_value("count", rd, 32'(count));
            axi_read(REG_CTRL, rd);
            check_value("ctrl", rd, {29'b0, mode, 1'b0});

            // Arming clears fill and waits for the trigger
            axi_write(REG_CTRL, {29'b0, mode, 1'b1});
            axi_read(REG_STATUS, rd);
            check_value("status", rd, {30'b0, ST_WAIT});

            nsamp = pat[p];
            gen   = (nsamp & GEN_FLAG) != 0;
            p = p + 1;
            for (idx = 0; idx < field_len(nsamp); idx++) begin
                if (gen) begin
                    send_sample(ramp_value(idx));
                end else begin
                    send_sample(pat[p + idx][7:0]);
                end
            end
            if (!gen) begin
                p = p + field_len(nsamp);
            end
            @(negedge clk);
            sample_valid = 1'b0;

            // Poll until the capture closes
            rd = '0;
            while (rd[1:0] !== ST_DONE) begin
                axi_read(REG_STATUS, rd);
            end
            check_value("status", rd, (32'(expected_fill(count)) << 8) | 32'(ST_DONE));

            // Buffer contents from the trigger sample on
            nexp = pat[p];
            gen  = (nexp & GEN_FLAG) != 0;
            p = p + 1;
            for (idx = 0; idx < field_len(nexp); idx++) begin
                exp_word = gen ? ramp_value(idx) : pat[p + idx][7:0];
                axi_read(BUF_BASE + 12'(4 * idx), rd);
                check_value("rdata", rd, 32'(exp_word));
            end
            if (!gen) begin
                p = p + field_len(nexp);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== scope_capture.f ====
logic/scope_pkg.sv
logic/trigger_detect.sv
logic/capture_sequencer.sv
logic/capture_buffer.sv
logic/axil_regs.sv
logic/scope_capture_top.sv
tests/scope_capture_tb.sv

// ==== tests/scope_capture_patterns.txt ====
// Case: mode level hyst count / n_samples then samples / n_expected then buffer words
// n with bit 15 set: generated ramp 7*i+3 of n[14:0] entries; FFFF ends the list
// Modes: 0 rising, 1 falling, 2 level, 3 immediate

// Rising, 82 crosses level before the dip to 70 and must not trigger
0000 0080 0010 0005
000C
0090 0085 007A 0082 006F 0075 0081 0079 0088 0060 0099 00A0
0005
0081 0079 0088 0060 0099

// Falling, arms at 65 above level+hyst, hits at 40
0001 0040 0020 0004
0009
0030 0050 003F 0065 0055 0040 0020 0070 0010
0004
0040 0020 0070 0010

// Level, first sample at or above C0, trailing 33 dropped
0002 00C0 0005 0003
0006
0010 00BF 00C0 0005 00FF 0033
0003
00C0 0005 00FF

// Immediate, first sample after arming
0003 0000 0000 0002
0003
005A 00A5 003C
0002
005A 00A5

// Immediate with count 0 fills the whole buffer, extra samples dropped
0003 0011 0022 0000
8104
8100

FFFF
